//--- common/icache_pkg.sv
package icache_pkg;

  // Address and data widths seen by the cores and the fill bus
  typedef logic [31:0] addr_t;   // Byte address
  typedef logic [31:0] word_t;   // Instruction word
  typedef logic [3:0]  rmask_t;  // Read byte mask, nonzero means request

  localparam int LINE_BYTES       = 32;
  localparam int LINE_OFFSET_BITS = $clog2(LINE_BYTES);

  typedef logic [LINE_BYTES*8-1:0] line_t;  // One full cache line

  // Per-cache sequencer
  typedef enum logic [1:0] {
    IDLE,     // Accepting, or looking up an accepted request
    FILL,     // Waiting on the shared bus
    INSTALL,  // Writing the fetched line
    INVAL     // Invalidate lookup
  } ctrl_state_t;

  // Fill bus arbiter
  typedef enum logic {
    ARB_IDLE,
    ARB_BUSY
  } arb_state_t;

endpackage

//--- icache/icache_control.sv
module icache_control (
  input  logic clk,
  input  logic rst,
  input  logic req_valid,
  input  logic inval_valid,
  input  logic cache_hit,
  input  logic bus_gnt,
  input  logic bus_resp,
  output logic ready,
  output logic bus_req,
  output logic install,
  output logic ufp_resp,
  output logic invalidate_resp
);
  import icache_pkg::*;

  ctrl_state_t state_q;
  logic        lookup_q;  // Core request accepted last edge, tag check in progress

  assign ready   = (state_q == IDLE) && !lookup_q;
  assign install = (state_q == INSTALL);

  // A miss asks for the bus already in the lookup cycle
  assign bus_req = (state_q == FILL) || (lookup_q && !cache_hit);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q         <= IDLE;
      lookup_q        <= 1'b0;
      ufp_resp        <= 1'b0;
      invalidate_resp <= 1'b0;
    end else begin
      ufp_resp        <= 1'b0;
      invalidate_resp <= 1'b0;
      case (state_q)
        IDLE: begin
          if (lookup_q) begin
            lookup_q <= 1'b0;
            if (cache_hit) begin
              ufp_resp <= 1'b1;
            end else begin
              state_q <= FILL;
            end
          end else if (inval_valid) begin  // Invalidate has priority
            state_q <= INVAL;
          end else if (req_valid) begin
            lookup_q <= 1'b1;
          end
        end
        FILL: begin
          if (bus_gnt && bus_resp) state_q <= INSTALL;  // Only our own response
        end
        INSTALL: begin
          state_q  <= IDLE;
          ufp_resp <= 1'b1;  // Line now present, word read out next cycle
        end
        INVAL: begin
          state_q         <= IDLE;
          invalidate_resp <= 1'b1;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  a_bus_req_held: assert property (@(posedge clk) disable iff (rst)
    bus_req && !(bus_gnt && bus_resp) |=> bus_req);

endmodule

//--- icache/icache.sv
module icache #(
  parameter int WAYS = 2,
  parameter int SETS = 8
) (
  input  logic               clk,
  input  logic               rst,
  input  icache_pkg::addr_t  ufp_addr,
  input  icache_pkg::rmask_t ufp_rmask,
  output icache_pkg::word_t  ufp_rdata,
  output logic               ufp_resp,
  input  logic               bus_gnt,
  input  icache_pkg::line_t  bus_rdata,
  input  logic               bus_resp,
  output logic               bus_req,
  output icache_pkg::addr_t  bus_addr,
  input  logic               invalidate_req,
  input  icache_pkg::addr_t  invalidate_addr,
  output logic               invalidate_resp,
  output icache_pkg::word_t  invalidate_wdata
);
  import icache_pkg::*;

  localparam int SET_BITS  = $clog2(SETS);
  localparam int TAG_BITS  = 32 - SET_BITS - LINE_OFFSET_BITS;
  localparam int WSEL_BITS = LINE_OFFSET_BITS - 2;

  logic [TAG_BITS-1:0] tag_q   [WAYS][SETS];
  line_t               data_q  [WAYS][SETS];
  logic [SETS-1:0]     valid_q [WAYS];
  logic [WAYS-1:0]     lru_q   [SETS][WAYS];  // Row r bit c: way r used after way c

  addr_t                lookup_addr;
  logic [SET_BITS-1:0]  set_idx;
  logic [TAG_BITS-1:0]  tag;
  logic [WSEL_BITS-1:0] word_idx;
  logic [WAYS-1:0]      hit_vec;
  logic [WAYS-1:0]      victim;
  logic                 victim_found;
  logic                 cache_hit;
  logic                 ready;
  logic                 install;
  word_t                word_sel;
  line_t                fill_q;

  // One address register serves both core lookups and invalidates
  always_ff @(posedge clk) begin
    if (rst) begin
      lookup_addr <= '0;
    end else if (ready) begin
      lookup_addr <= invalidate_req ? invalidate_addr : ufp_addr;
    end
  end

  assign word_idx = lookup_addr[2 +: WSEL_BITS];
  assign set_idx  = lookup_addr[LINE_OFFSET_BITS +: SET_BITS];
  assign tag      = lookup_addr[31 -: TAG_BITS];
  assign bus_addr = {lookup_addr[31:LINE_OFFSET_BITS], LINE_OFFSET_BITS'(0)};

  always_comb begin
    hit_vec  = '0;
    word_sel = '0;  // Stays zero on a miss
    for (int w = 0; w < WAYS; w++) begin
      if (valid_q[w][set_idx] && tag_q[w][set_idx] == tag) begin
        hit_vec[w] = 1'b1;
        word_sel   = data_q[w][set_idx][word_idx*32 +: 32];
      end
    end
  end

  assign cache_hit        = |hit_vec;
  assign ufp_rdata        = word_sel;
  assign invalidate_wdata = word_sel;  // Read before the valid bit drops

  // Replacement: an empty way first, else the way nobody was used before
  always_comb begin
    victim       = '0;
    victim_found = 1'b0;
    for (int w = 0; w < WAYS; w++) begin
      if (!victim_found && !valid_q[w][set_idx]) begin
        victim[w]    = 1'b1;
        victim_found = 1'b1;
      end
    end
    for (int w = 0; w < WAYS; w++) begin
      if (!victim_found && lru_q[set_idx][w] == '0) begin
        victim[w]    = 1'b1;
        victim_found = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (bus_gnt && bus_resp) fill_q <= bus_rdata;  // Bus data lasts one cycle
  end

  always_ff @(posedge clk) begin
    for (int w = 0; w < WAYS; w++) begin
      if (install && victim[w]) begin
        tag_q[w][set_idx]  <= tag;
        data_q[w][set_idx] <= fill_q;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int w = 0; w < WAYS; w++) begin
        valid_q[w] <= '0;
      end
    end else begin
      for (int w = 0; w < WAYS; w++) begin
        if (install && victim[w]) begin
          valid_q[w][set_idx] <= 1'b1;
        end else if (invalidate_resp && hit_vec[w]) begin
          valid_q[w][set_idx] <= 1'b0;
        end
      end
    end
  end

  // Every core response is a hit, direct or right after an install
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < SETS; s++) begin
        for (int r = 0; r < WAYS; r++) begin
          lru_q[s][r] <= '0;
        end
      end
    end else if (ufp_resp) begin
      for (int r = 0; r < WAYS; r++) begin
        for (int c = 0; c < WAYS; c++) begin
          if (hit_vec[r] && r != c) begin
            lru_q[set_idx][r][c] <= 1'b1;
          end else if (hit_vec[c]) begin
            lru_q[set_idx][r][c] <= 1'b0;
          end
        end
      end
    end
  end

  icache_control u_control (
    .clk             (clk),
    .rst             (rst),
    .req_valid       (|ufp_rmask),
    .inval_valid     (invalidate_req),
    .cache_hit       (cache_hit),
    .bus_gnt         (bus_gnt),
    .bus_resp        (bus_resp),
    .ready           (ready),
    .bus_req         (bus_req),
    .install         (install),
    .ufp_resp        (ufp_resp),
    .invalidate_resp (invalidate_resp)
  );

  a_hit_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(hit_vec));

  a_resp_excl: assert property (@(posedge clk) disable iff (rst)
    !(ufp_resp && invalidate_resp));

endmodule

//--- hdl/bus_arbiter.sv
module bus_arbiter #(
  parameter int NUM_CACHES = 2
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [NUM_CACHES-1:0] bus_req,
  input  icache_pkg::addr_t     bus_addr [NUM_CACHES],
  input  logic                  mem_resp,
  output logic [NUM_CACHES-1:0] bus_gnt,
  output logic                  mem_read,
  output icache_pkg::addr_t     mem_addr
);
  import icache_pkg::*;

  localparam int IDX_BITS = (NUM_CACHES > 1) ? $clog2(NUM_CACHES) : 1;

  arb_state_t          state_q;
  logic [IDX_BITS-1:0] last_q;  // Latest grant, also steers the address
  logic [IDX_BITS-1:0] pick;
  logic                pick_valid;

  // Search starts one past the last winner
  always_comb begin
    int idx;
    pick       = last_q;
    pick_valid = 1'b0;
    for (int i = 1; i <= NUM_CACHES; i++) begin
      idx = (int'(last_q) + i) % NUM_CACHES;
      if (!pick_valid && bus_req[idx]) begin
        pick       = IDX_BITS'(idx);
        pick_valid = 1'b1;
      end
    end
  end

  assign mem_addr = bus_addr[last_q];

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q  <= ARB_IDLE;
      bus_gnt  <= '0;
      mem_read <= 1'b0;
      last_q   <= IDX_BITS'(NUM_CACHES - 1);  // Cache 0 wins the first tie
    end else begin
      mem_read <= 1'b0;
      case (state_q)
        ARB_IDLE: begin
          if (pick_valid) begin
            bus_gnt       <= '0;
            bus_gnt[pick] <= 1'b1;
            last_q        <= pick;
            mem_read      <= 1'b1;  // One strobe per grant
            state_q       <= ARB_BUSY;
          end
        end
        ARB_BUSY: begin
          if (mem_resp) begin
            bus_gnt <= '0;
            state_q <= ARB_IDLE;
          end
        end
        default: state_q <= ARB_IDLE;
      endcase
    end
  end

  a_gnt_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(bus_gnt));

endmodule

//--- hdl/line_memory.sv
module line_memory #(
  parameter int MEM_LINES   = 16,
  parameter int MEM_LATENCY = 4
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              mem_read,
  input  icache_pkg::addr_t mem_addr,
  output icache_pkg::line_t mem_rdata,
  output logic              mem_resp
);
  import icache_pkg::*;

  localparam int IDX_BITS = $clog2(MEM_LINES);
  localparam int CNT_BITS = $clog2(MEM_LATENCY + 1);

  line_t               lines_q [MEM_LINES];
  logic [IDX_BITS-1:0] line_idx;
  logic [CNT_BITS-1:0] cnt_q;
  logic                busy_q;

  initial begin
    $readmemh("mem_image.hex", lines_q);
  end

  // Line number wraps over the image
  assign line_idx = IDX_BITS'(mem_addr[31:LINE_OFFSET_BITS] % MEM_LINES);

  always_ff @(posedge clk) begin
    if (mem_read) mem_rdata <= lines_q[line_idx];  // Held until the next read
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q   <= 1'b0;
      cnt_q    <= '0;
      mem_resp <= 1'b0;
    end else begin
      mem_resp <= 1'b0;
      if (mem_read) begin
        cnt_q    <= CNT_BITS'(MEM_LATENCY - 1);
        busy_q   <= (MEM_LATENCY > 1);
        mem_resp <= (MEM_LATENCY == 1);
      end else if (busy_q) begin
        cnt_q <= cnt_q - 1'b1;
        if (cnt_q == CNT_BITS'(1)) begin
          busy_q   <= 1'b0;
          mem_resp <= 1'b1;
        end
      end
    end
  end

  a_no_overlap: assert property (@(posedge clk) disable iff (rst) mem_read |-> !busy_q);

endmodule

//--- hdl/icache_cluster.sv
module icache_cluster #(
  parameter int  WAYS        = 2,
  parameter int  SETS        = 8,
  parameter int  MEM_LINES   = 16,
  parameter int  MEM_LATENCY = 4,
  localparam int NUM_CACHES  = 2
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  icache_pkg::addr_t  [NUM_CACHES-1:0]  ufp_addr,
  input  icache_pkg::rmask_t [NUM_CACHES-1:0]  ufp_rmask,
  output icache_pkg::word_t  [NUM_CACHES-1:0]  ufp_rdata,
  output logic               [NUM_CACHES-1:0]  ufp_resp,
  input  logic               [NUM_CACHES-1:0]  invalidate_req,
  input  icache_pkg::addr_t  [NUM_CACHES-1:0]  invalidate_addr,
  output logic               [NUM_CACHES-1:0]  invalidate_resp,
  output icache_pkg::word_t  [NUM_CACHES-1:0]  invalidate_wdata
);
  import icache_pkg::*;

  logic [NUM_CACHES-1:0] bus_req;
  logic [NUM_CACHES-1:0] bus_gnt;
  addr_t                 bus_addr [NUM_CACHES];
  logic                  mem_read;
  addr_t                 mem_addr;
  line_t                 mem_rdata;
  logic                  mem_resp;

  // Fill data is broadcast, each cache takes it only under its grant
  for (genvar i = 0; i < NUM_CACHES; i++) begin : gen_cache
    icache #(
      .WAYS (WAYS),
      .SETS (SETS)
    ) u_icache (
      .clk              (clk),
      .rst              (rst),
      .ufp_addr         (ufp_addr[i]),
      .ufp_rmask        (ufp_rmask[i]),
      .ufp_rdata        (ufp_rdata[i]),
      .ufp_resp         (ufp_resp[i]),
      .bus_gnt          (bus_gnt[i]),
      .bus_rdata        (mem_rdata),
      .bus_resp         (mem_resp),
      .bus_req          (bus_req[i]),
      .bus_addr         (bus_addr[i]),
      .invalidate_req   (invalidate_req[i]),
      .invalidate_addr  (invalidate_addr[i]),
      .invalidate_resp  (invalidate_resp[i]),
      .invalidate_wdata (invalidate_wdata[i])
    );
  end

  bus_arbiter #(
    .NUM_CACHES (NUM_CACHES)
  ) u_arbiter (
    .clk      (clk),
    .rst      (rst),
    .bus_req  (bus_req),
    .bus_addr (bus_addr),
    .mem_resp (mem_resp),
    .bus_gnt  (bus_gnt),
    .mem_read (mem_read),
    .mem_addr (mem_addr)
  );

  line_memory #(
    .MEM_LINES   (MEM_LINES),
    .MEM_LATENCY (MEM_LATENCY)
  ) u_memory (
    .clk       (clk),
    .rst       (rst),
    .mem_read  (mem_read),
    .mem_addr  (mem_addr),
    .mem_rdata (mem_rdata),
    .mem_resp  (mem_resp)
  );

endmodule

//--- dv/icache_cluster_tb.sv
module icache_cluster_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import icache_pkg::*;

  localparam int WAYS        = 2;
  localparam int SETS        = 8;
  localparam int MEM_LINES   = 16;
  localparam int MEM_LATENCY = 4;
  localparam int MISS_MIN    = MEM_LATENCY + 3;
  localparam int WAIT_LIMIT  = 4 * MEM_LATENCY + 20;
  localparam int DRIVE_DELAY = 10;

  // Test lines, set index is address bits [7:5]
  localparam addr_t LINE_T1  = 32'h0000_0820;  // Set 1
  localparam addr_t LINE_T2A = 32'h0000_04a0;  // Set 5
  localparam addr_t LINE_T2B = 32'h0000_00c0;  // Set 6
  localparam addr_t SET3_A   = 32'h0000_0060;
  localparam addr_t SET3_B   = 32'h0000_0160;
  localparam addr_t SET3_C   = 32'h0000_0260;
  localparam addr_t LINE_T4  = 32'h0000_0340;  // Set 2
  localparam addr_t ABSENT_A = 32'h0000_00e0;  // Set 7, never read
  localparam addr_t ABSENT_B = 32'h0000_01e0;

  logic         clk = 1'b0;
  logic         rst;
  addr_t  [1:0] ufp_addr;
  rmask_t [1:0] ufp_rmask;
  word_t  [1:0] ufp_rdata;
  logic   [1:0] ufp_resp;
  logic   [1:0] invalidate_req;
  addr_t  [1:0] invalidate_addr;
  logic   [1:0] invalidate_resp;
  word_t  [1:0] invalidate_wdata;

  line_t      image [MEM_LINES];
  word_t      exp_rdata [2];
  word_t      exp_wdata [2];
  logic [1:0] rd_pending;   // Read issued, response still owed
  logic [1:0] inv_pending;
  int         last_lat [2];
  int         errors;
  int         timeouts;
  integer     seed = 32'h9ddd_deb1;
  string      test_name;

  always #50 clk = ~clk;

  icache_cluster #(
    .WAYS        (WAYS),
    .SETS        (SETS),
    .MEM_LINES   (MEM_LINES),
    .MEM_LATENCY (MEM_LATENCY)
  ) DUT (
    .clk              (clk),
    .rst              (rst),
    .ufp_addr         (ufp_addr),
    .ufp_rmask        (ufp_rmask),
    .ufp_rdata        (ufp_rdata),
    .ufp_resp         (ufp_resp),
    .invalidate_req   (invalidate_req),
    .invalidate_addr  (invalidate_addr),
    .invalidate_resp  (invalidate_resp),
    .invalidate_wdata (invalidate_wdata)
  );

  // Expected word straight from the memory image
  function automatic word_t model_word(input addr_t a);
    line_t l;
    l = image[(a / 32) % MEM_LINES];
    return l[a[4:2] * 32 +: 32];
  endfunction

  function automatic addr_t rand_offset();
    return addr_t'($random(seed)) & 32'h0000_001c;  // Word aligned
  endfunction

  for (genvar i = 0; i < 2; i++) begin : gen_check
    a_read_issued: assert property (@(posedge clk) disable iff (rst)
      ufp_resp[i] |-> rd_pending[i])
      else begin
        $display("%s: cache %0d sent a read response with no read outstanding",
                 test_name, i);
        errors++;
      end
    a_read_data: assert property (@(posedge clk) disable iff (rst)
      ufp_resp[i] && rd_pending[i] |-> ufp_rdata[i] == exp_rdata[i])
      else begin
        $display("error %s: cache %0d rdata expected %h actual %h",
                 test_name, i, exp_rdata[i], $sampled(ufp_rdata[i]));
        errors++;
      end
    a_inval_issued: assert property (@(posedge clk) disable iff (rst)
      invalidate_resp[i] |-> inv_pending[i])
      else begin
        $display("%s: cache %0d answered an invalidate that was never sent",
                 test_name, i);
        errors++;
      end
    a_inval_data: assert property (@(posedge clk) disable iff (rst)
      invalidate_resp[i] && inv_pending[i] |-> invalidate_wdata[i] == exp_wdata[i])
      else begin
        $display("error %s: cache %0d wdata expected %h actual %h",
                 test_name, i, exp_wdata[i], $sampled(invalidate_wdata[i]));
        errors++;
      end
  end

  task automatic start_read(input int c, input addr_t a);
    ufp_addr[c]   = a;
    ufp_rmask[c]  = 4'hf;
    exp_rdata[c]  = model_word(a);
    rd_pending[c] = 1'b1;
  endtask

  // Starts just after the accepting edge, ends on the edge after the response
  task automatic wait_read(input int c, input int min_lat, input int max_lat);
    int   n;
    logic seen;
    n           = 0;
    seen        = 1'b0;
    last_lat[c] = 0;
    while (!seen && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
      seen = ufp_resp[c];
    end
    if (!seen) begin
      $display("%s: timeout, cache %0d never answered the read", test_name, c);
      timeouts++;
    end else begin
      last_lat[c] = n - 1;
      a_read_latency: assert (n - 1 >= min_lat && n - 1 <= max_lat) else begin
        $display("error %s: cache %0d latency expected %0d to %0d actual %0d",
                 test_name, c, min_lat, max_lat, n - 1);
        errors++;
      end
    end
    @(posedge clk);
    rd_pending[c] = 1'b0;
  endtask

  task automatic read_word(input int c, input addr_t a, input int min_lat, input int max_lat);
    #DRIVE_DELAY;
    start_read(c, a);
    @(posedge clk);  // Cache is idle, request taken here
    #DRIVE_DELAY;
    ufp_rmask[c] = '0;
    wait_read(c, min_lat, max_lat);
  endtask

  task automatic start_invalidate(input int c, input addr_t a, input word_t expected);
    invalidate_addr[c] = a;
    invalidate_req[c]  = 1'b1;
    exp_wdata[c]       = expected;
    inv_pending[c]     = 1'b1;
  endtask

  task automatic wait_invalidate(input int c);
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
      seen = invalidate_resp[c];
    end
    if (!seen) begin
      $display("%s: timeout, cache %0d never answered the invalidate", test_name, c);
      timeouts++;
    end else begin
      a_inval_latency: assert (n - 1 == 1) else begin
        $display("error %s: cache %0d invalidate latency expected 1 actual %0d",
                 test_name, c, n - 1);
        errors++;
      end
    end
    @(posedge clk);
    inv_pending[c] = 1'b0;
  endtask

  task automatic invalidate_line(input int c, input addr_t a, input word_t expected);
    #DRIVE_DELAY;
    start_invalidate(c, a, expected);
    @(posedge clk);
    #DRIVE_DELAY;
    invalidate_req[c] = 1'b0;
    wait_invalidate(c);
  endtask

  initial begin
    addr_t a;
    rst             = 1'b1;
    ufp_addr        = '0;
    ufp_rmask       = '0;
    invalidate_req  = '0;
    invalidate_addr = '0;
    rd_pending      = '0;
    inv_pending     = '0;
    errors          = 0;
    timeouts        = 0;
    test_name       = "reset";
    $readmemh("mem_image.hex", image);
    repeat (2) @(posedge clk);
    #DRIVE_DELAY rst = 1'b0;
    @(posedge clk);
    a_reset_quiet: assert (ufp_resp == '0 && invalidate_resp == '0) else begin
      $display("responses were not low after reset");
      errors++;
    end

    test_name = "cold_miss_then_hit";
    read_word(0, LINE_T1 | rand_offset(), MISS_MIN, WAIT_LIMIT);
    read_word(0, LINE_T1 | rand_offset(), 1, 1);
    #DRIVE_DELAY;
    ufp_addr[0]  = LINE_T1 + 32'h20;
    ufp_rmask[0] = '0;  // No request, so no response may appear
    repeat (2 * MISS_MIN) @(posedge clk);

    test_name = "shared_bus";
    #DRIVE_DELAY;
    start_read(0, LINE_T2A | rand_offset());
    start_read(1, LINE_T2B | rand_offset());
    @(posedge clk);
    #DRIVE_DELAY;
    ufp_rmask = '0;
    fork
      wait_read(0, MISS_MIN, WAIT_LIMIT);
      wait_read(1, MISS_MIN, WAIT_LIMIT);
    join
    a_serialized: assert (last_lat[0] >= 2 * MEM_LATENCY + 3 ||
                          last_lat[1] >= 2 * MEM_LATENCY + 3) else begin
      $display("%s: both misses finished too early for one shared bus", test_name);
      errors++;
    end

    test_name = "lru_replacement";
    read_word(0, SET3_A | rand_offset(), MISS_MIN, WAIT_LIMIT);
    read_word(0, SET3_B | rand_offset(), MISS_MIN, WAIT_LIMIT);
    read_word(0, SET3_A | rand_offset(), 1, 1);  // A becomes most recent
    read_word(0, SET3_C | rand_offset(), MISS_MIN, WAIT_LIMIT);
    read_word(0, SET3_A | rand_offset(), 1, 1);
    read_word(0, SET3_B | rand_offset(), MISS_MIN, WAIT_LIMIT);

    test_name = "invalidate_present";
    read_word(1, LINE_T4 | rand_offset(), MISS_MIN, WAIT_LIMIT);
    a = LINE_T4 | rand_offset();
    invalidate_line(1, a, model_word(a));
    read_word(1, LINE_T4 | rand_offset(), MISS_MIN, WAIT_LIMIT);

    test_name = "invalidate_absent";
    invalidate_line(0, ABSENT_A | rand_offset(), '0);
    if ($random(seed) & 1) begin
      read_word(0, LINE_T1 | rand_offset(), 1, 1);
      read_word(0, SET3_A | rand_offset(), 1, 1);
    end else begin
      read_word(0, SET3_A | rand_offset(), 1, 1);
      read_word(0, LINE_T1 | rand_offset(), 1, 1);
    end

    test_name = "invalidate_before_read";
    #DRIVE_DELAY;
    start_invalidate(0, ABSENT_B | rand_offset(), '0);
    start_read(0, LINE_T1 | rand_offset());
    @(posedge clk);  // Invalidate wins, read stays held
    #DRIVE_DELAY;
    invalidate_req[0] = 1'b0;
    wait_invalidate(0);  // Returns on the edge that takes the read
    #DRIVE_DELAY;
    ufp_rmask[0] = '0;
    wait_read(0, 1, 1);

    $display("Run complete: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- mem_image.hex
// One 256-bit memory line per row, row n is line n
// Word 7 is the leftmost 8 digits, word 0 the rightmost
e0075a07e0065a06e0055a05e0045a04e0035a03e0025a02e0015a01e0005a00
e1075a17e1065a16e1055a15e1045a14e1035a13e1025a12e1015a11e1005a10
e2075a27e2065a26e2055a25e2045a24e2035a23e2025a22e2015a21e2005a20
e3075a37e3065a36e3055a35e3045a34e3035a33e3025a32e3015a31e3005a30
e4075a47e4065a46e4055a45e4045a44e4035a43e4025a42e4015a41e4005a40
e5075a57e5065a56e5055a55e5045a54e5035a53e5025a52e5015a51e5005a50
e6075a67e6065a66e6055a65e6045a64e6035a63e6025a62e6015a61e6005a60
e7075a77e7065a76e7055a75e7045a74e7035a73e7025a72e7015a71e7005a70
e8075a87e8065a86e8055a85e8045a84e8035a83e8025a82e8015a81e8005a80
e9075a97e9065a96e9055a95e9045a94e9035a93e9025a92e9015a91e9005a90
ea075aa7ea065aa6ea055aa5ea045aa4ea035aa3ea025aa2ea015aa1ea005aa0
eb075ab7eb065ab6eb055ab5eb045ab4eb035ab3eb025ab2eb015ab1eb005ab0
ec075ac7ec065ac6ec055ac5ec045ac4ec035ac3ec025ac2ec015ac1ec005ac0
ed075ad7ed065ad6ed055ad5ed045ad4ed035ad3ed025ad2ed015ad1ed005ad0
ee075ae7ee065ae6ee055ae5ee045ae4ee035ae3ee025ae2ee015ae1ee005ae0
ef075af7ef065af6ef055af5ef045af4ef035af3ef025af2ef015af1ef005af0

//--- list.f
common/icache_pkg.sv
icache/icache_control.sv
icache/icache.sv
hdl/bus_arbiter.sv
hdl/line_memory.sv
hdl/icache_cluster.sv
dv/icache_cluster_tb.sv

//--- Bender.yml
package:
  name: icache_cluster

sources:
  - files:
      - common/icache_pkg.sv
      - icache/icache_control.sv
      - icache/icache.sv
      - hdl/bus_arbiter.sv
      - hdl/line_memory.sv
      - hdl/icache_cluster.sv
  - target: test
    files:
      - dv/icache_cluster_tb.sv
